// File: rtl/rob_settings.svh
// Reorder buffer sizing
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Number of in-flight instructions the buffer can hold
`define ROB_DEPTH 16

// Tag width, log2 of the depth
`define ROB_TAG_W 4

// Result width carried on the CDBs and written at retirement
`define ROB_DATA_W 32

// Program counter width
`define ROB_ADDR_W 32

// Architectural register index width
`define ROB_REG_W 5

// Number of common data buses
`define ROB_CDB_N 2

// Number of source operand lookup ports
`define ROB_LOOKUP_N 2

`endif

// File: rtl/rob_pkg.sv
// Reorder buffer types
`include "rob_settings.svh"

package rob_pkg;

    // Payload written into a reserved slot the cycle after reservation
    typedef struct packed {
        logic [`ROB_ADDR_W-1:0] pc;
        logic [`ROB_REG_W-1:0]  rdst;
    } dispatch_t;

    // One completion broadcast from an execution unit
    typedef struct packed {
        logic                   en;
        logic                   redirect;
        logic [`ROB_TAG_W-1:0]  tag;
        logic [`ROB_DATA_W-1:0] data;
    } cdb_t;

    // Retiring instruction as seen by the register file
    typedef struct packed {
        logic [`ROB_TAG_W-1:0]  tag;
        logic [`ROB_REG_W-1:0]  rdst;
        logic [`ROB_DATA_W-1:0] data;
    } retire_t;

    // A slot goes from free to waiting for its result and then to result present
    typedef enum logic [1:0] {
        ENTRY_FREE = 2'd0,
        ENTRY_WAIT = 2'd1,
        ENTRY_DONE = 2'd2
    } entry_state_e;

endpackage

// File: rtl/rob_queue_ctrl.sv
// Circular queue pointers
`timescale 1ns/1ps

module rob_queue_ctrl #(
    parameter int DEPTH = 16,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_flush,
    input  logic             i_incr_head,
    input  logic             i_incr_tail,
    output logic [IDX_W-1:0] o_head,
    output logic [IDX_W-1:0] o_tail,
    output logic             o_full,
    output logic             o_empty
);

    logic [IDX_W-1:0]   head;
    logic [IDX_W-1:0]   tail;
    logic [IDX_W:0]     count;

    // Pointers wrap explicitly so a depth that is not a power of two still works
    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (i_incr_head) begin
                head <= (head == IDX_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            if (i_incr_tail) begin
                tail <= (tail == IDX_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            // Simultaneous push and pop leave the occupancy unchanged
            if (i_incr_tail && !i_incr_head) begin
                count <= count + 1'b1;
            end else if (i_incr_head && !i_incr_tail) begin
                count <= count - 1'b1;
            end
        end
    end

    assign o_head  = head;
    assign o_tail  = tail;
    assign o_full  = (count == (IDX_W+1)'(DEPTH));
    assign o_empty = (count == '0);

    // The head may only move over an occupied slot
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (i_reset) i_incr_head |-> !o_empty
    );

endmodule

// File: rtl/rob_entry.sv
// Reorder buffer slot
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_entry (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_flush,
    input  logic [`ROB_TAG_W-1:0]   i_tag,
    input  logic                    i_dispatch_en,
    input  rob_pkg::dispatch_t      i_dispatch,
    input  rob_pkg::cdb_t           i_cdb [`ROB_CDB_N],
    input  logic                    i_retire_en,
    output rob_pkg::entry_state_e   o_state,
    output logic [`ROB_ADDR_W-1:0]  o_pc,
    output logic [`ROB_REG_W-1:0]   o_rdst,
    output logic [`ROB_DATA_W-1:0]  o_data,
    output logic                    o_redirect
);

    rob_pkg::entry_state_e      state;
    logic                       cdb_hit;
    logic                       cdb_redirect;
    logic [`ROB_DATA_W-1:0]     cdb_data;

    // Tags on different buses are distinct, so at most one bus can match
    always_comb begin
        cdb_hit      = 1'b0;
        cdb_redirect = 1'b0;
        cdb_data     = '0;
        for (int c = 0; c < `ROB_CDB_N; c++) begin
            if (i_cdb[c].en && (i_cdb[c].tag == i_tag)) begin
                cdb_hit      = 1'b1;
                cdb_redirect = i_cdb[c].redirect;
                cdb_data     = i_cdb[c].data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= rob_pkg::ENTRY_FREE;
        end else if (i_flush || i_retire_en) begin
            state <= rob_pkg::ENTRY_FREE;
        end else if (i_dispatch_en) begin
            state <= rob_pkg::ENTRY_WAIT;
        end else if ((state == rob_pkg::ENTRY_WAIT) && cdb_hit) begin
            state <= rob_pkg::ENTRY_DONE;
        end
    end

    // Payload is captured on dispatch and on completion
    always_ff @(posedge clk) begin
        if (i_dispatch_en) begin
            o_pc   <= i_dispatch.pc;
            o_rdst <= i_dispatch.rdst;
        end
        if ((state == rob_pkg::ENTRY_WAIT) && cdb_hit) begin
            o_data     <= cdb_data;
            o_redirect <= cdb_redirect;
        end
    end

    assign o_state = state;

    // A slot is filled only after it was handed out free by the tail pointer
    a_dispatch_free: assert property (
        @(posedge clk) disable iff (i_reset)
        (i_dispatch_en && !i_flush) |-> (state == rob_pkg::ENTRY_FREE)
    );

endmodule

// File: rtl/rob.sv
// Reorder buffer
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_reserve_en,
    output logic [`ROB_TAG_W-1:0]   o_reserve_tag,
    output logic                    o_stall,
    input  logic                    i_dispatch_en,
    input  rob_pkg::dispatch_t      i_dispatch,
    input  rob_pkg::cdb_t           i_cdb [`ROB_CDB_N],
    input  logic [`ROB_TAG_W-1:0]   i_lookup_tag [`ROB_LOOKUP_N],
    output logic                    o_lookup_rdy [`ROB_LOOKUP_N],
    output logic [`ROB_DATA_W-1:0]  o_lookup_data [`ROB_LOOKUP_N],
    output logic                    o_retire_en,
    output rob_pkg::retire_t        o_retire,
    output logic                    o_redirect,
    output logic [`ROB_ADDR_W-1:0]  o_redirect_pc
);

    logic [`ROB_TAG_W-1:0]  head;
    logic [`ROB_TAG_W-1:0]  tail;
    logic                   full;

    rob_pkg::entry_state_e  entry_state    [`ROB_DEPTH];
    logic [`ROB_ADDR_W-1:0] entry_pc       [`ROB_DEPTH];
    logic [`ROB_REG_W-1:0]  entry_rdst     [`ROB_DEPTH];
    logic [`ROB_DATA_W-1:0] entry_data     [`ROB_DEPTH];
    logic                   entry_redirect [`ROB_DEPTH];

    logic [`ROB_DEPTH-1:0]  reserve_select;
    logic [`ROB_DEPTH-1:0]  dispatch_select_r;
    logic [`ROB_DEPTH-1:0]  retire_select;
    logic                   reserve_en;
    logic                   retire_en;
    logic                   redirect;
    logic                   redirect_r;

    // While the redirect is reported the buffer is being flushed,
    // so nothing new may enter and nothing younger may retire
    assign reserve_en = i_reserve_en && !redirect_r;
    assign retire_en  = (entry_state[head] == rob_pkg::ENTRY_DONE) && !redirect_r;
    assign redirect   = retire_en && entry_redirect[head];

    rob_queue_ctrl #(
        .DEPTH(`ROB_DEPTH)
    ) u_queue_ctrl (
        .clk(clk),
        .i_reset(i_reset),
        .i_flush(redirect_r),
        .i_incr_head(retire_en),
        .i_incr_tail(reserve_en),
        .o_head(head),
        .o_tail(tail),
        .o_full(full),
        .o_empty()
    );

    // The slot reserved now is filled by the dispatcher next cycle
    always_comb begin
        reserve_select       = '0;
        reserve_select[tail] = reserve_en;
        retire_select        = '0;
        retire_select[head]  = retire_en;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            dispatch_select_r <= '0;
        end else begin
            dispatch_select_r <= reserve_select;
        end
    end

    for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_entry
        rob_entry u_entry (
            .clk(clk),
            .i_reset(i_reset),
            .i_flush(redirect_r),
            .i_tag((`ROB_TAG_W)'(i)),
            .i_dispatch_en(dispatch_select_r[i] && i_dispatch_en && !redirect_r),
            .i_dispatch(i_dispatch),
            .i_cdb(i_cdb),
            .i_retire_en(retire_select[i]),
            .o_state(entry_state[i]),
            .o_pc(entry_pc[i]),
            .o_rdst(entry_rdst[i]),
            .o_data(entry_data[i]),
            .o_redirect(entry_redirect[i])
        );
    end

    // Retirement and redirect are reported one cycle after the head completes
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_retire_en <= 1'b0;
            redirect_r  <= 1'b0;
        end else begin
            o_retire_en <= retire_en;
            redirect_r  <= redirect;
        end
    end

    always_ff @(posedge clk) begin
        o_retire.tag  <= head;
        o_retire.rdst <= entry_rdst[head];
        o_retire.data <= entry_data[head];
        if (redirect) begin
            o_redirect_pc <= entry_pc[head];
        end
    end

    assign o_redirect    = redirect_r;
    assign o_reserve_tag = tail;
    assign o_stall       = full || redirect_r;

    // Source operand lookup; a result on a CDB this cycle overrides the stored copy
    always_comb begin
        for (int l = 0; l < `ROB_LOOKUP_N; l++) begin
            o_lookup_rdy[l]  = (entry_state[i_lookup_tag[l]] == rob_pkg::ENTRY_DONE);
            o_lookup_data[l] = entry_data[i_lookup_tag[l]];
            for (int c = 0; c < `ROB_CDB_N; c++) begin
                if (i_cdb[c].en && (i_cdb[c].tag == i_lookup_tag[l])) begin
                    o_lookup_rdy[l]  = 1'b1;
                    o_lookup_data[l] = i_cdb[c].data;
                end
            end
        end
    end

    // The dispatcher has to honor the stall
    a_no_reserve_stalled: assert property (
        @(posedge clk) disable iff (i_reset) o_stall |-> !i_reserve_en
    );

endmodule

// File: rtl/arch_regfile.sv
// Architectural register file
`timescale 1ns/1ps
`include "rob_settings.svh"

module arch_regfile (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_retire_en,
    input  rob_pkg::retire_t        i_retire,
    input  logic [`ROB_REG_W-1:0]   i_rd_idx,
    output logic [`ROB_DATA_W-1:0]  o_rd_data
);

    localparam int NUM_REGS = 1 << `ROB_REG_W;

    logic [`ROB_DATA_W-1:0] regs [NUM_REGS];
    logic                   wr_en;

    // Register 0 is hardwired to zero, so retirements that target it are dropped
    assign wr_en = i_retire_en && (i_retire.rdst != '0);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            regs[i_retire.rdst] <= i_retire.data;
        end
    end

    // Combinational read; a write in this cycle shows up next cycle
    assign o_rd_data = regs[i_rd_idx];

endmodule

// File: rtl/rob_top.sv
// Retirement block top level
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_top (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_reserve_en,
    output logic [`ROB_TAG_W-1:0]   o_reserve_tag,
    output logic                    o_stall,
    input  logic                    i_dispatch_en,
    input  rob_pkg::dispatch_t      i_dispatch,
    input  rob_pkg::cdb_t           i_cdb [`ROB_CDB_N],
    input  logic [`ROB_TAG_W-1:0]   i_lookup_tag [`ROB_LOOKUP_N],
    output logic                    o_lookup_rdy [`ROB_LOOKUP_N],
    output logic [`ROB_DATA_W-1:0]  o_lookup_data [`ROB_LOOKUP_N],
    output logic                    o_retire_en,
    output rob_pkg::retire_t        o_retire,
    output logic                    o_redirect,
    output logic [`ROB_ADDR_W-1:0]  o_redirect_pc,
    input  logic [`ROB_REG_W-1:0]   i_rd_idx,
    output logic [`ROB_DATA_W-1:0]  o_rd_data
);

    rob u_rob (
        .clk(clk),
        .i_reset(i_reset),
        .i_reserve_en(i_reserve_en),
        .o_reserve_tag(o_reserve_tag),
        .o_stall(o_stall),
        .i_dispatch_en(i_dispatch_en),
        .i_dispatch(i_dispatch),
        .i_cdb(i_cdb),
        .i_lookup_tag(i_lookup_tag),
        .o_lookup_rdy(o_lookup_rdy),
        .o_lookup_data(o_lookup_data),
        .o_retire_en(o_retire_en),
        .o_retire(o_retire),
        .o_redirect(o_redirect),
        .o_redirect_pc(o_redirect_pc)
    );

    // Retirements go straight into the register file
    arch_regfile u_regfile (
        .clk(clk),
        .i_reset(i_reset),
        .i_retire_en(o_retire_en),
        .i_retire(o_retire),
        .i_rd_idx(i_rd_idx),
        .o_rd_data(o_rd_data)
    );

endmodule

// File: test/rob_checker.sv
// Reference model and output checker
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_checker (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_reserve_en,
    input  logic                    i_dispatch_en,
    input  rob_pkg::dispatch_t      i_dispatch,
    input  rob_pkg::cdb_t           i_cdb [`ROB_CDB_N],
    input  logic [`ROB_TAG_W-1:0]   i_lookup_tag [`ROB_LOOKUP_N],
    input  logic [`ROB_REG_W-1:0]   i_rd_idx,
    input  logic [`ROB_TAG_W-1:0]   i_reserve_tag,
    input  logic                    i_stall,
    input  logic                    i_lookup_rdy [`ROB_LOOKUP_N],
    input  logic [`ROB_DATA_W-1:0]  i_lookup_data [`ROB_LOOKUP_N],
    input  logic                    i_retire_en,
    input  rob_pkg::retire_t        i_retire,
    input  logic                    i_redirect,
    input  logic [`ROB_ADDR_W-1:0]  i_redirect_pc,
    input  logic [`ROB_DATA_W-1:0]  i_rd_data,
    output int                      o_errors
);

    localparam int NUM_REGS = 1 << `ROB_REG_W;

    // Model state, indexed by tag, plus the program order of live tags
    rob_pkg::entry_state_e  st [`ROB_DEPTH];
    rob_pkg::dispatch_t     info [`ROB_DEPTH];
    logic [`ROB_DATA_W-1:0] done_data [`ROB_DEPTH];
    logic                   done_redir [`ROB_DEPTH];
    logic [`ROB_TAG_W-1:0]  order [$];
    logic [`ROB_TAG_W-1:0]  tail;
    logic [`ROB_DATA_W-1:0] shadow [NUM_REGS];

    logic                   dispatch_pending;
    logic [`ROB_TAG_W-1:0]  dispatch_tag;
    logic                   flush_next;
    logic                   exp_retire_en;
    rob_pkg::retire_t       exp_retire;
    logic [`ROB_ADDR_W-1:0] exp_pc;
    int                     errors = 0;

    assign o_errors = errors;

    task automatic check_that(input logic ok, input string what);
        if (!ok) begin
            errors++;
            $display("** Error at %0t ns: %s", $time, what);
        end
    endtask

    task automatic empty_model();
        order.delete();
        tail             = '0;
        dispatch_pending = 1'b0;
        exp_retire_en    = 1'b0;
        flush_next       = 1'b0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            st[i] = rob_pkg::ENTRY_FREE;
        end
    endtask

    task automatic compare_outputs();
        logic                   rdy;
        logic [`ROB_DATA_W-1:0] data;
        logic [`ROB_TAG_W-1:0]  tag;
        check_that(i_stall === ((order.size() == `ROB_DEPTH) || flush_next),
            $sformatf("stall is %0b with %0d entries held", i_stall, order.size()));
        check_that(i_reserve_tag === tail,
            $sformatf("reserve tag %0d, expected %0d", i_reserve_tag, tail));
        check_that(i_retire_en === exp_retire_en,
            $sformatf("retire enable %0b, expected %0b", i_retire_en, exp_retire_en));
        if (exp_retire_en) begin
            check_that(i_retire === exp_retire,
                $sformatf("retire %h, expected %h", i_retire, exp_retire));
        end
        check_that(i_redirect === flush_next,
            $sformatf("redirect %0b, expected %0b", i_redirect, flush_next));
        if (flush_next) begin
            check_that(i_redirect_pc === exp_pc,
                $sformatf("redirect pc %h, expected %h", i_redirect_pc, exp_pc));
        end
        for (int l = 0; l < `ROB_LOOKUP_N; l++) begin
            tag  = i_lookup_tag[l];
            rdy  = (st[tag] == rob_pkg::ENTRY_DONE);
            data = done_data[tag];
            // A result broadcast in this very cycle is forwarded
            for (int c = 0; c < `ROB_CDB_N; c++) begin
                if (i_cdb[c].en && (i_cdb[c].tag == tag)) begin
                    rdy  = 1'b1;
                    data = i_cdb[c].data;
                end
            end
            check_that(i_lookup_rdy[l] === rdy,
                $sformatf("lookup %0d tag %0d ready %0b, expected %0b", l, tag,
                          i_lookup_rdy[l], rdy));
            if (rdy) begin
                check_that(i_lookup_data[l] === data,
                    $sformatf("lookup %0d data %h, expected %h", l, i_lookup_data[l], data));
            end
        end
        check_that(i_rd_data === shadow[i_rd_idx],
            $sformatf("reg %0d reads %h, expected %h", i_rd_idx, i_rd_data, shadow[i_rd_idx]));
    endtask

    // Advances the model across the coming clock edge
    task automatic step_model();
        logic [`ROB_TAG_W-1:0] head;
        logic                  retire_now;
        // The retire reported now is written at this edge
        if (exp_retire_en && (exp_retire.rdst != '0)) begin
            shadow[exp_retire.rdst] = exp_retire.data;
        end
        if (flush_next) begin
            empty_model();
            return;
        end
        head       = (order.size() > 0) ? order[0] : '0;
        retire_now = (order.size() > 0) && (st[head] == rob_pkg::ENTRY_DONE);
        for (int c = 0; c < `ROB_CDB_N; c++) begin
            if (i_cdb[c].en && (st[i_cdb[c].tag] == rob_pkg::ENTRY_WAIT)) begin
                st[i_cdb[c].tag]         = rob_pkg::ENTRY_DONE;
                done_data[i_cdb[c].tag]  = i_cdb[c].data;
                done_redir[i_cdb[c].tag] = i_cdb[c].redirect;
            end
        end
        if (dispatch_pending && i_dispatch_en) begin
            st[dispatch_tag]   = rob_pkg::ENTRY_WAIT;
            info[dispatch_tag] = i_dispatch;
        end
        exp_retire_en = retire_now;
        flush_next    = retire_now && done_redir[head];
        if (retire_now) begin
            exp_retire.tag  = head;
            exp_retire.rdst = info[head].rdst;
            exp_retire.data = done_data[head];
            exp_pc          = info[head].pc;
            st[head]        = rob_pkg::ENTRY_FREE;
            void'(order.pop_front());
        end
        dispatch_pending = i_reserve_en;
        dispatch_tag     = tail;
        if (i_reserve_en) begin
            order.push_back(tail);
            tail = tail + 1'b1;
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (i_reset) begin
            empty_model();
            for (int r = 0; r < NUM_REGS; r++) begin
                shadow[r] = '0;
            end
        end else begin
            compare_outputs();
            step_model();
        end
    end

endmodule

// File: test/tb_rob.sv
// Reorder buffer testbench
`timescale 1ns/1ps
`include "rob_settings.svh"

module tb_rob;

    localparam int RANDOM_CYCLES = 4000;
    localparam int DRAIN_LIMIT   = 2000;

    logic                   clk;
    logic                   i_reset;
    logic                   i_reserve_en;
    logic [`ROB_TAG_W-1:0]  o_reserve_tag;
    logic                   o_stall;
    logic                   i_dispatch_en;
    rob_pkg::dispatch_t     i_dispatch;
    rob_pkg::cdb_t          i_cdb [`ROB_CDB_N];
    logic [`ROB_TAG_W-1:0]  i_lookup_tag [`ROB_LOOKUP_N];
    logic                   o_lookup_rdy [`ROB_LOOKUP_N];
    logic [`ROB_DATA_W-1:0] o_lookup_data [`ROB_LOOKUP_N];
    logic                   o_retire_en;
    rob_pkg::retire_t       o_retire;
    logic                   o_redirect;
    logic [`ROB_ADDR_W-1:0] o_redirect_pc;
    logic [`ROB_REG_W-1:0]  i_rd_idx;
    logic [`ROB_DATA_W-1:0] o_rd_data;
    int                     errors;

    // Dispatched tags without a result and reserved slots not yet retired
    logic [`ROB_TAG_W-1:0]  inflight [$];
    int                     occupancy;
    logic                   redirect_pending;
    logic                   reserve_on;
    logic                   timed_out;
    int                     drain_cycles;
    int                     pick;
    rob_pkg::cdb_t          cdb;

    rob_top uut (.*);

    rob_checker u_checker (
        .clk(clk),
        .i_reset(i_reset),
        .i_reserve_en(i_reserve_en),
        .i_dispatch_en(i_dispatch_en),
        .i_dispatch(i_dispatch),
        .i_cdb(i_cdb),
        .i_lookup_tag(i_lookup_tag),
        .i_rd_idx(i_rd_idx),
        .i_reserve_tag(o_reserve_tag),
        .i_stall(o_stall),
        .i_lookup_rdy(o_lookup_rdy),
        .i_lookup_data(o_lookup_data),
        .i_retire_en(o_retire_en),
        .i_retire(o_retire),
        .i_redirect(o_redirect),
        .i_redirect_pc(o_redirect_pc),
        .i_rd_data(o_rd_data),
        .o_errors(errors)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (!i_reset) begin
            // Values read here belong to the cycle that is ending
            if (o_redirect) begin
                inflight.delete();
                occupancy        = 0;
                redirect_pending = 1'b0;
            end else begin
                occupancy = occupancy + int'(i_reserve_en) - int'(o_retire_en);
            end
            // Completions come slower than reserves so the buffer fills up at times
            for (int c = 0; c < `ROB_CDB_N; c++) begin
                cdb = '0;
                if ((inflight.size() > 0) && ($urandom_range(3) == 0)) begin
                    pick             = $urandom_range(inflight.size() - 1);
                    cdb.en           = 1'b1;
                    cdb.tag          = inflight[pick];
                    cdb.redirect     = ($urandom_range(99) < 5);
                    cdb.data         = $urandom;
                    redirect_pending = redirect_pending || cdb.redirect;
                    inflight.delete(pick);
                end
                i_cdb[c] <= cdb;
            end
            // The slot reserved in the ending cycle is filled in the next one
            i_dispatch_en   <= i_reserve_en && !o_redirect;
            i_dispatch.pc   <= $urandom;
            i_dispatch.rdst <= (`ROB_REG_W)'($urandom);
            if (i_reserve_en && !o_redirect) begin
                inflight.push_back(o_reserve_tag);
            end
            // Occupancy still counts the retire of this edge, so it never undershoots
            i_reserve_en <= reserve_on && !redirect_pending && (occupancy < `ROB_DEPTH)
                && ($urandom_range(3) != 0);
            for (int l = 0; l < `ROB_LOOKUP_N; l++) begin
                i_lookup_tag[l] <= (`ROB_TAG_W)'($urandom);
            end
            i_rd_idx <= (`ROB_REG_W)'($urandom);
        end
    end

    initial begin
        void'($urandom(32'h95a09f6f));
        clk              = 1'b0;
        i_reset          = 1'b1;
        i_reserve_en     = 1'b0;
        i_dispatch_en    = 1'b0;
        i_dispatch       = '0;
        i_rd_idx         = '0;
        for (int c = 0; c < `ROB_CDB_N; c++) begin
            i_cdb[c] = '0;
        end
        for (int l = 0; l < `ROB_LOOKUP_N; l++) begin
            i_lookup_tag[l] = '0;
        end
        occupancy        = 0;
        redirect_pending = 1'b0;
        reserve_on       = 1'b0;
        timed_out        = 1'b0;
        repeat (10) @(posedge clk);
        i_reset    <= 1'b0;
        reserve_on <= 1'b1;
        repeat (RANDOM_CYCLES) @(posedge clk);
        reserve_on <= 1'b0;

        // Drain until every reserved instruction has retired
        drain_cycles = 0;
        @(negedge clk);
        while (!timed_out && ((occupancy != 0) || (inflight.size() != 0) || i_reserve_en)) begin
            @(negedge clk);
            drain_cycles++;
            if (drain_cycles > DRAIN_LIMIT) begin
                $display("Drain timed out with %0d instructions still outstanding", occupancy);
                timed_out = 1'b1;
            end
        end
        repeat (4) @(negedge clk);

        $display("Checker errors: %0d, drain timeouts: %0d", errors, timed_out ? 1 : 0);
        if (!timed_out && (errors == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_queue_ctrl.sv
rtl/rob_entry.sv
rtl/rob.sv
rtl/arch_regfile.sv
rtl/rob_top.sv
test/rob_checker.sv
test/tb_rob.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_rob -o tb_rob
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_rob)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Verification passed"; then
    exit 0
fi
exit 1
